// File: source/serdes_pkg.sv
`default_nettype none

// datapath defaults shared by the lanes and the control
package serdes_pkg;

	// ------------------------------------------------------------------
	// word framing
	localparam int DEFAULT_WORD_WIDTH = 8; // bits per word on each lane
	localparam int DEFAULT_LANES = 4; // quad by default, 1 or 2 also fine

	// ------------------------------------------------------------------
	// clocking model
	localparam int DEFAULT_LOCK_CYCLES = 16; // stands in for pll lock time

	// line level when nothing is offered, gives the all-ones idle word
	localparam logic IDLE_LEVEL = 1'b1;

endpackage

`default_nettype wire

// File: source/link_ctrl_pkg.sv
`default_nettype none

// link state encoding, shared by the control FSM and the bound properties
package link_ctrl_pkg;

	typedef enum logic [1:0] {
		LINK_LOCKING = 2'd0, // waiting out the modelled pll lock
		LINK_ALIGNING = 2'd1, // one word period to line up the strobe
		LINK_RUNNING = 2'd2 // strobe running, locked high
	} link_state_e;

endpackage

`default_nettype wire

// File: source/serdes_link_control.sv
`default_nettype none
`timescale 1ns/1ps

// single control block for all lanes: lock delay, strobe alignment,
// word strobe generation and the transmit-side handshake
module serdes_link_control
	import serdes_pkg::*, link_ctrl_pkg::*;
#(
	parameter int WORD_WIDTH = DEFAULT_WORD_WIDTH,
	parameter int LOCK_CYCLES = DEFAULT_LOCK_CYCLES
) (
	input wire clock,
	input wire rst, // sync, active high
	input wire word_valid, // from the word source
	output logic word_ready, // one cycle per word period
	output logic word_strobe, // load / capture pulse to every lane
	output logic word_take, // strobe qualified by valid, tx lanes only
	output logic word_out_valid, // rx word presented this cycle
	output logic locked // high exactly while running
);

	localparam int LCW = $clog2(LOCK_CYCLES + 1); // lock counter width
	localparam int BCW = $clog2(WORD_WIDTH + 1); // bit counter width

	link_state_e state; // lock / align / run
	logic [LCW-1:0] lock_count; // cycles spent in LINK_LOCKING
	logic [BCW-1:0] bit_count; // position within the word period
	logic last_bit; // bit counter at WORD_WIDTH-1

	assign last_bit = (bit_count == BCW'(WORD_WIDTH - 1));

	// ------------------------------------------------------------------
	// link FSM and counters
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= LINK_LOCKING;
			lock_count <= '0;
			bit_count <= '0;
			locked <= 1'b0;
		end else begin
			case (state)
				LINK_LOCKING: begin
					lock_count <= lock_count + 1'b1; // count lock delay
					if (lock_count == LCW'(LOCK_CYCLES - 1)) begin
						state <= LINK_ALIGNING; // lock acquired
					end
				end
				LINK_ALIGNING: begin
					if (last_bit) begin
						state <= LINK_RUNNING; // strobe lined up after one word
						locked <= 1'b1; // registered, follows the state
					end
				end
				LINK_RUNNING: begin
					state <= LINK_RUNNING; // only reset leaves here
				end
				default: begin
					state <= LINK_LOCKING; // unused encoding, start over
					locked <= 1'b0;
				end
			endcase
			// bit counter runs in align and run, wraps to zero so that
			// it is back at zero on entry to LINK_RUNNING
			if (state != LINK_LOCKING) begin
				bit_count <= last_bit ? '0 : bit_count + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// strobe and handshake
	assign word_strobe = (state == LINK_RUNNING) && last_bit; // once per word
	assign word_ready = word_strobe; // never looks at word_valid
	assign word_take = word_strobe & word_valid; // transfer decided here once

	always_ff @(posedge clock) begin
		if (rst) begin
			word_out_valid <= 1'b0;
		end else begin
			word_out_valid <= word_strobe; // rx word lands one cycle later
		end
	end

endmodule

`default_nettype wire

// File: source/oserdes_lane.sv
`default_nettype none
`timescale 1ns/1ps

// one transmit lane: parallel load on the strobe, msb out first
module oserdes_lane
	import serdes_pkg::*;
#(
	parameter int WORD_WIDTH = DEFAULT_WORD_WIDTH
) (
	input wire clock,
	input wire rst,
	input wire word_strobe, // word boundary
	input wire word_take, // load the offered word instead of idle
	input wire [WORD_WIDTH-1:0] word, // this lane's slice of word_in
	output logic D_out // serial line
);

	localparam logic [WORD_WIDTH-1:0] IDLE_WORD = {WORD_WIDTH{IDLE_LEVEL}};

	logic [WORD_WIDTH-1:0] shifter; // msb is on the line

	always_ff @(posedge clock) begin
		if (rst) begin
			shifter <= IDLE_WORD; // line idles high from reset
		end else if (word_strobe) begin
			if (word_take) begin
				shifter <= word; // accepted word
			end else begin
				shifter <= IDLE_WORD; // nothing offered, send idle
			end
		end else begin
			shifter <= {shifter[WORD_WIDTH-2:0], IDLE_LEVEL}; // toward msb
		end
	end

	assign D_out = shifter[WORD_WIDTH-1]; // msb leaves first

endmodule

`default_nettype wire

// File: source/iserdes_lane.sv
`default_nettype none
`timescale 1ns/1ps

// one receive lane: samples every cycle, presents a word on the strobe
module iserdes_lane
	import serdes_pkg::*;
#(
	parameter int WORD_WIDTH = DEFAULT_WORD_WIDTH
) (
	input wire clock,
	input wire rst,
	input wire word_strobe, // capture point
	input wire data_in, // serial line
	output logic [WORD_WIDTH-1:0] word_out // last captured word
);

	localparam logic [WORD_WIDTH-1:0] IDLE_WORD = {WORD_WIDTH{IDLE_LEVEL}};

	logic [WORD_WIDTH-2:0] shifter; // previous WORD_WIDTH-1 samples
	logic [WORD_WIDTH-1:0] assembled; // samples plus the current bit

	assign assembled = {shifter, data_in}; // oldest sample ends up as msb

	always_ff @(posedge clock) begin
		shifter <= assembled[WORD_WIDTH-2:0]; // shift in every cycle
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			word_out <= IDLE_WORD; // matches an idle line
		end else if (word_strobe) begin
			word_out <= assembled; // hold until the next strobe
		end
	end

endmodule

`default_nettype wire

// File: source/ocyrus_link.sv
`default_nettype none
`timescale 1ns/1ps

// multi-lane word serializer with a matching deserializer,
// one control block drives the strobe for every lane
module ocyrus_link
	import serdes_pkg::*;
#(
	parameter int WORD_WIDTH = DEFAULT_WORD_WIDTH,
	parameter int LANES = DEFAULT_LANES,
	parameter int LOCK_CYCLES = DEFAULT_LOCK_CYCLES
) (
	input wire clock,
	input wire rst, // sync, active high
	input wire word_valid, // offer for all lanes at once
	output wire word_ready, // transfer when valid and ready
	input wire [LANES*WORD_WIDTH-1:0] word_in, // lane 0 in the low bits
	output wire [LANES-1:0] D_out, // serial out, one per lane
	input wire [LANES-1:0] data_in, // serial in, one per lane
	output wire [LANES*WORD_WIDTH-1:0] word_out, // same layout as word_in
	output wire word_out_valid, // one cycle per received word
	output wire locked // link running
);

	wire word_strobe; // shared word boundary
	wire word_take; // strobe and valid, tx lanes only

	// ------------------------------------------------------------------
	// control
	serdes_link_control #(
		.WORD_WIDTH(WORD_WIDTH),
		.LOCK_CYCLES(LOCK_CYCLES)
	) control (
		.clock(clock),
		.rst(rst),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.word_strobe(word_strobe),
		.word_take(word_take),
		.word_out_valid(word_out_valid),
		.locked(locked)
	);

	// ------------------------------------------------------------------
	// transmit lanes
	for (genvar lane = 0; lane < LANES; lane++) begin : g_tx
		oserdes_lane #(
			.WORD_WIDTH(WORD_WIDTH)
		) tx (
			.clock(clock),
			.rst(rst),
			.word_strobe(word_strobe),
			.word_take(word_take),
			.word(word_in[lane*WORD_WIDTH +: WORD_WIDTH]), // this lane's slice
			.D_out(D_out[lane])
		);
	end

	// ------------------------------------------------------------------
	// receive lanes
	for (genvar lane = 0; lane < LANES; lane++) begin : g_rx
		iserdes_lane #(
			.WORD_WIDTH(WORD_WIDTH)
		) rx (
			.clock(clock),
			.rst(rst),
			.word_strobe(word_strobe), // same strobe as tx, loopback lines up
			.data_in(data_in[lane]),
			.word_out(word_out[lane*WORD_WIDTH +: WORD_WIDTH])
		);
	end

endmodule

`default_nettype wire

// File: sim/ocyrus_link_properties.sv
`default_nettype none
`timescale 1ns/1ps

// handshake and strobe timing seen from the top level
module ocyrus_link_properties
	import link_ctrl_pkg::*;
#(
	parameter int WORD_WIDTH = 8
) (
	input wire clock,
	input wire rst,
	input wire word_ready,
	input wire word_out_valid,
	input wire locked,
	input link_state_e state // control FSM state
);

	// ------------------------------------------------------------------
	// handshake
	a_ready_locked: assert property (@(posedge clock) disable iff (rst)
		word_ready |-> locked)
		else $error("word_ready high while the link is not locked");

	// quiet for WORD_WIDTH-1 cycles after each ready
	for (genvar k = 1; k < WORD_WIDTH; k++) begin : g_quiet
		a_ready_quiet: assert property (@(posedge clock) disable iff (rst)
			$past(word_ready, k) |-> !word_ready)
			else $error("word_ready high again %0d cycles after the last one", k);
	end

	a_ready_period: assert property (@(posedge clock) disable iff (rst)
		$past(word_ready, WORD_WIDTH) |-> word_ready)
		else $error("word_ready missing one word period after the last one");

	// ------------------------------------------------------------------
	// receive side and lock
	a_out_valid: assert property (@(posedge clock) disable iff (rst)
		word_out_valid == $past(word_ready))
		else $error("word_out_valid is not word_ready delayed by one cycle");

	a_lock_held: assert property (@(posedge clock) disable iff (rst)
		!$fell(locked))
		else $error("locked dropped while out of reset");

	a_lock_state: assert property (@(posedge clock) disable iff (rst)
		locked == (state == LINK_RUNNING)) // registered flag tracks the FSM
		else $error("locked disagrees with the link state");

endmodule

bind ocyrus_link ocyrus_link_properties #(
	.WORD_WIDTH(WORD_WIDTH)
) props (
	.clock(clock),
	.rst(rst),
	.word_ready(word_ready),
	.word_out_valid(word_out_valid),
	.locked(locked),
	.state(control.state)
);

`default_nettype wire

// File: sim/ocyrus_link_tb.sv
`default_nettype none
`timescale 1ns/1ps

module ocyrus_link_tb
	import serdes_pkg::*;
;

	localparam int WORD_WIDTH = DEFAULT_WORD_WIDTH;
	localparam int LANES = DEFAULT_LANES;
	localparam int LOCK_CYCLES = DEFAULT_LOCK_CYCLES;
	localparam int BUS = LANES * WORD_WIDTH; // flat word bus, lane 0 low
	localparam int WORD_COUNT = 64;
	localparam int CYCLE_LIMIT = 20 + LOCK_CYCLES + WORD_WIDTH * (5 * WORD_COUNT + 8);
	localparam logic [BUS-1:0] IDLE_BUS = '1; // all lanes idle high

	logic clock;
	logic rst;
	logic word_valid;
	logic [BUS-1:0] word_in;
	wire word_ready;
	wire [LANES-1:0] D_out;
	wire [LANES-1:0] data_in;
	wire [BUS-1:0] word_out;
	wire word_out_valid;
	wire locked;

	integer seed; // $random state
	int error_count = 0;
	int cycle_count = 0; // run length guard
	logic [BUS-1:0] offered_q[$]; // words in offer order, never popped

	// expected link behavior, built from the timing rules
	int post_rst; // cycles since reset release, saturates at lock
	int phase; // position in the word period once locked
	int accept_count; // words taken at a strobe
	int recv_index; // next offered word expected on word_out
	logic [BUS-1:0] sent_word; // word on the lines this period
	logic [BUS-1:0] rx_expect; // word the rx side should present
	logic exp_out_valid;
	wire exp_locked = (post_rst == LOCK_CYCLES + WORD_WIDTH);
	wire exp_ready = exp_locked && (phase == WORD_WIDTH - 1); // last bit of a period
	wire [LANES-1:0] exp_dout;

	ocyrus_link #(
		.WORD_WIDTH(WORD_WIDTH),
		.LANES(LANES),
		.LOCK_CYCLES(LOCK_CYCLES)
	) UUT (
		.clock(clock),
		.rst(rst),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.word_in(word_in),
		.D_out(D_out),
		.data_in(data_in),
		.word_out(word_out),
		.word_out_valid(word_out_valid),
		.locked(locked)
	);

	assign data_in = D_out; // zero-delay loopback

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period
	end

	// picks one bit per lane out of a flat word
	function automatic logic [LANES-1:0] serial_bits_at(input logic [BUS-1:0] w,
			input int bit_index);
		logic [LANES-1:0] bits;
		for (int l = 0; l < LANES; l++) begin
			bits[l] = w[l*WORD_WIDTH + bit_index];
		end
		return bits;
	endfunction

	assign exp_dout = serial_bits_at(sent_word, WORD_WIDTH - 1 - phase); // msb first

	function automatic logic [BUS-1:0] random_word();
		logic [BUS-1:0] w;
		for (int l = 0; l < LANES; l++) begin
			w[l*WORD_WIDTH +: WORD_WIDTH] = WORD_WIDTH'($random(seed));
		end
		if (w == IDLE_BUS) begin
			w[0] = 1'b0; // keep data words apart from idle
		end
		return w;
	endfunction

	// ------------------------------------------------------------------
	// reference model
	always @(posedge clock) begin
		if (rst) begin
			post_rst <= 0;
			phase <= 0;
			accept_count <= 0;
			recv_index <= 0;
			sent_word <= IDLE_BUS; // lines idle from reset
			rx_expect <= IDLE_BUS;
			exp_out_valid <= 1'b0;
		end else begin
			if (post_rst < LOCK_CYCLES + WORD_WIDTH) begin
				post_rst <= post_rst + 1; // lock delay then one align word
			end
			if (exp_locked) begin
				phase <= (phase == WORD_WIDTH - 1) ? 0 : phase + 1;
			end
			if (exp_ready) begin
				rx_expect <= sent_word; // last period's word lands on rx
				sent_word <= word_valid ? word_in : IDLE_BUS;
				if (word_valid) begin
					accept_count <= accept_count + 1;
				end
			end
			exp_out_valid <= exp_ready;
			if (word_out_valid && word_out != IDLE_BUS) begin
				recv_index <= recv_index + 1;
			end
		end
	end

	// ------------------------------------------------------------------
	// checks
	a_locked: assert property (@(posedge clock) disable iff (rst) locked == exp_locked)
		else begin
			error_count++;
			$display("Mismatch locked: expected %h, actual %h",
				$sampled(exp_locked), $sampled(locked));
		end

	a_ready: assert property (@(posedge clock) disable iff (rst) word_ready == exp_ready)
		else begin
			error_count++;
			$display("Mismatch word_ready: expected %h, actual %h",
				$sampled(exp_ready), $sampled(word_ready));
		end

	a_dout: assert property (@(posedge clock) disable iff (rst) D_out == exp_dout)
		else begin
			error_count++;
			$display("Mismatch D_out: expected %h, actual %h", $sampled(exp_dout), $sampled(D_out));
		end

	a_out_valid: assert property (@(posedge clock) disable iff (rst)
		word_out_valid == exp_out_valid)
		else begin
			error_count++;
			$display("Mismatch word_out_valid: expected %h, actual %h",
				$sampled(exp_out_valid), $sampled(word_out_valid));
		end

	a_word_out: assert property (@(posedge clock) disable iff (rst)
		word_out_valid |-> word_out == rx_expect)
		else begin
			error_count++;
			$display("Mismatch word_out: expected %h, actual %h",
				$sampled(rx_expect), $sampled(word_out));
		end

	// received data words against the offer order
	a_order: assert property (@(posedge clock) disable iff (rst)
		(word_out_valid && word_out != IDLE_BUS) |->
		(recv_index < offered_q.size() && word_out == offered_q[recv_index]))
		else begin
			error_count++;
			$display("Mismatch word_out order: expected %h, actual %h",
				$sampled(offered_q[recv_index]), $sampled(word_out));
		end

	// ------------------------------------------------------------------
	// stimulus
	task automatic step();
		@(posedge clock);
		#0.5; // drive point
	endtask

	task automatic skip_strobes(input int n);
		repeat (n) begin
			while (!word_ready) step();
			step(); // strobe passes with valid low
		end
	endtask

	task automatic send_word(input logic [BUS-1:0] w);
		word_in = w;
		word_valid = 1'b1;
		while (!word_ready) step(); // held until the strobe
		step();
		word_valid = 1'b0;
		word_in = random_word(); // junk, must not be loaded
	endtask

	initial begin
		int gap;
		seed = 32'h0488_16d3;
		rst = 1'b1;
		word_valid = 1'b0;
		word_in = '0;
		repeat (10) @(posedge clock);
		#0.5;
		rst = 1'b0;
		for (int i = 0; i < WORD_COUNT; i++) begin
			gap = $random(seed) & 3;
			if (i == WORD_COUNT / 2) begin
				gap = 4; // longer idle stretch mid run
			end
			skip_strobes(gap);
			offered_q.push_back(random_word());
			send_word(offered_q[i]);
		end
		skip_strobes(3); // drain the last word through the loopback
		step();
		a_counts: assert (accept_count == WORD_COUNT && recv_index == WORD_COUNT)
			else begin
				error_count++;
				$display("words lost or repeated: %0d offered, %0d accepted, %0d received",
					WORD_COUNT, accept_count, recv_index);
			end
		$display("words offered %0d, accepted %0d, received %0d, errors %0d",
			offered_q.size(), accept_count, recv_index, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles, %0d errors so far",
				CYCLE_LIMIT, error_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: ocyrus_link.f
source/serdes_pkg.sv
source/link_ctrl_pkg.sv
source/serdes_link_control.sv
source/oserdes_lane.sv
source/iserdes_lane.sv
source/ocyrus_link.sv
sim/ocyrus_link_properties.sv
sim/ocyrus_link_tb.sv

// File: Makefile
# Verilator build for the serializer link testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ocyrus_link_tb
FILELIST  := ocyrus_link.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation output is scanned for the pass line, nothing is written to disk
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
